// ==== project.f ====
design/dbg_ahb_pkg.sv
design/dbg_biu_ahb.sv
design/ahb_master_arbiter.sv
design/ahb_sram_slave.sv
design/dbg_ahb_top.sv
bench/dbg_ahb_checker.sv
bench/tb_dbg_ahb.sv

// ==== bench/tb_dbg_ahb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the two-port debug hub, applies an operation
// table to both ports and leaves the comparing to the checker
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_dbg_ahb
  import dbg_ahb_pkg::*;
();

  logic                       HCLK;
  logic                       ahb_rstn;
  // Port inputs, index is the port number
  logic [1:0]                 strb;
  logic [1:0]                 rw;
  logic [1:0][addr_width-1:0] addr;
  logic [1:0][data_width-1:0] wdata;
  logic [1:0][3:0]            word_size;
  wire  [1:0][data_width-1:0] rdata;
  wire  [1:0]                 rdy;
  wire  [1:0]                 err;
  // Expectations handed to the checker
  logic [1:0][data_width-1:0] exp_rdata;
  logic [1:0]                 exp_err;
  logic [1:0]                 exp_chk;
  logic [1:0][7:0]            test_no;
  wire  [31:0]                pass_count;
  wire  [31:0]                fail_count;
  int                         timeouts;
  int                         n_ops;

  ////////////////////////////////////////////////////////////
  // Operation table
  ////////////////////////////////////////////////////////////

  // Pair starts the next entry in the same cycle
  // Stray sends a second strobe while the first is in flight
  bit          op_port  [32];
  bit          op_pair  [32];
  bit          op_rd    [32];
  logic [3:0]  op_size  [32];
  logic [31:0] op_addr  [32];
  logic [31:0] op_wdata [32];
  logic [31:0] op_exp   [32];
  bit          op_err   [32];
  bit          op_stray [32];

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  dbg_ahb_top dut (
    .HCLK            (HCLK),
    .ahb_rstn        (ahb_rstn),
    .dbg_strb_0      (strb[0]),
    .dbg_rw_0        (rw[0]),
    .dbg_addr_0      (addr[0]),
    .dbg_wdata_0     (wdata[0]),
    .dbg_word_size_0 (word_size[0]),
    .dbg_rdata_0     (rdata[0]),
    .dbg_rdy_0       (rdy[0]),
    .dbg_err_0       (err[0]),
    .dbg_strb_1      (strb[1]),
    .dbg_rw_1        (rw[1]),
    .dbg_addr_1      (addr[1]),
    .dbg_wdata_1     (wdata[1]),
    .dbg_word_size_1 (word_size[1]),
    .dbg_rdata_1     (rdata[1]),
    .dbg_rdy_1       (rdy[1]),
    .dbg_err_1       (err[1])
  );

  dbg_ahb_checker u_checker (
    .HCLK       (HCLK),
    .ahb_rstn   (ahb_rstn),
    .rdy        (rdy),
    .err        (err),
    .rdata      (rdata),
    .exp_rdata  (exp_rdata),
    .exp_err    (exp_err),
    .exp_chk    (exp_chk),
    .test_no    (test_no),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  task automatic add_op(input bit port, input bit pair, input bit rd, input logic [3:0] size,
                        input logic [31:0] a, input logic [31:0] wd, input logic [31:0] ex,
                        input bit e, input bit stray);
    op_port[n_ops]  = port;
    op_pair[n_ops]  = pair;
    op_rd[n_ops]    = rd;
    op_size[n_ops]  = size;
    op_addr[n_ops]  = a;
    op_wdata[n_ops] = wd;
    op_exp[n_ops]   = ex;
    op_err[n_ops]   = e;
    op_stray[n_ops] = stray;
    n_ops++;
  endtask

  // port, pair, read, size, address, write data, read data, err, stray
  task automatic load_table();
    n_ops = 0;
    // Word across ports
    add_op(0, 0, 0, 4, 32'h010, 32'hA5C3_1E7F, 32'h0, 0, 0);
    add_op(1, 0, 1, 4, 32'h010, 32'h0, 32'hA5C3_1E7F, 0, 0);
    // Lane writes into a known word, then lane reads
    add_op(0, 0, 0, 4, 32'h020, 32'h1122_3344, 32'h0, 0, 0);
    add_op(1, 0, 0, 1, 32'h021, 32'h0000_00AB, 32'h0, 0, 0);
    add_op(0, 0, 0, 2, 32'h022, 32'h0000_CDEF, 32'h0, 0, 0);
    add_op(1, 0, 1, 4, 32'h020, 32'h0, 32'hCDEF_AB44, 0, 0);
    add_op(0, 0, 1, 1, 32'h020, 32'h0, 32'h0000_0044, 0, 0);
    add_op(1, 0, 1, 1, 32'h021, 32'h0, 32'h0000_00AB, 0, 0);
    add_op(0, 0, 1, 1, 32'h023, 32'h0, 32'h0000_00CD, 0, 0);
    add_op(1, 0, 1, 2, 32'h020, 32'h0, 32'h0000_AB44, 0, 0);
    add_op(0, 0, 1, 2, 32'h022, 32'h0, 32'h0000_CDEF, 0, 0);
    // Out of range accesses
    // Address 0x410 aliases word 0x010 in its low bits
    add_op(0, 0, 0, 4, 32'h410, 32'hDEAD_BEEF, 32'h0, 1, 0);
    add_op(0, 0, 1, 4, 32'h010, 32'h0, 32'hA5C3_1E7F, 0, 0);
    add_op(1, 0, 1, 1, 32'h400, 32'h0, 32'h0, 1, 0);
    add_op(1, 0, 1, 4, 32'h000, 32'h0, 32'h0, 0, 0);
    // Simultaneous pairs
    add_op(0, 1, 0, 4, 32'h040, 32'h0BAD_F00D, 32'h0, 0, 0);
    add_op(1, 0, 0, 4, 32'h080, 32'h600D_CAFE, 32'h0, 0, 0);
    add_op(0, 1, 1, 4, 32'h080, 32'h0, 32'h600D_CAFE, 0, 0);
    add_op(1, 0, 1, 4, 32'h040, 32'h0, 32'h0BAD_F00D, 0, 0);
    // Strobes while busy
    // Stray target at address + 4 stays zero
    add_op(0, 0, 0, 4, 32'h0C0, 32'h1357_9BDF, 32'h0, 0, 1);
    add_op(1, 0, 1, 4, 32'h0C0, 32'h0, 32'h1357_9BDF, 0, 0);
    add_op(1, 0, 1, 4, 32'h0C4, 32'h0, 32'h0, 0, 0);
    add_op(1, 0, 1, 4, 32'h010, 32'h0, 32'hA5C3_1E7F, 0, 1);
    add_op(0, 0, 1, 4, 32'h014, 32'h0, 32'h0, 0, 0);
  endtask

  ////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////

  task automatic launch(input int i);
    int p;
    p = op_port[i];
    strb[p]      <= 1'b1;
    rw[p]        <= op_rd[i];
    addr[p]      <= op_addr[i];
    wdata[p]     <= op_wdata[i];
    word_size[p] <= op_size[i];
    exp_rdata[p] <= op_exp[i];
    exp_err[p]   <= op_err[i];
    exp_chk[p]   <= op_rd[i] & ~op_err[i];
    test_no[p]   <= 8'(i + 1);
  endtask

  // Write of all ones that must never reach the memory
  task automatic send_stray(input int i);
    int p;
    p = op_port[i];
    strb[p]      <= 1'b1;
    rw[p]        <= 1'b0;
    addr[p]      <= op_addr[i] + 32'd4;
    wdata[p]     <= 32'hFFFF_FFFF;
    word_size[p] <= 4'd4;
  endtask

  // Bounded wait for rdy
  // First poll one edge later
  task automatic wait_rdy(input int i);
    int p;
    int cycles;
    p = op_port[i];
    cycles = 0;
    do begin
      @(posedge HCLK);
      cycles++;
    end while (!rdy[p] && cycles < 40);
    if (!rdy[p]) begin
      timeouts++;
      $display("Timeout: port %0d never raised rdy for test %0d", p, i + 1);
    end
  endtask

  initial begin
    int i;
    int gap;
    void'($urandom(83439));
    ahb_rstn  = 1'b0;
    strb      = '0;
    rw        = '0;
    addr      = '0;
    wdata     = '0;
    word_size = '0;
    exp_rdata = '0;
    exp_err   = '0;
    exp_chk   = '0;
    test_no   = '0;
    timeouts  = 0;
    load_table();
    repeat (5) @(posedge HCLK);
    ahb_rstn <= 1'b1;
    i = 0;
    while (i < n_ops) begin
      // Random idle gap before each strobe
      gap = $urandom % 4;
      repeat (gap + 1) @(posedge HCLK);
      launch(i);
      if (op_pair[i]) begin
        launch(i + 1);
      end
      @(posedge HCLK);
      if (op_stray[i]) begin
        send_stray(i);
        @(posedge HCLK);
      end
      strb <= 2'b00;
      wait_rdy(i);
      if (op_pair[i]) begin
        wait_rdy(i + 1);
        i = i + 2;
      end else begin
        i = i + 1;
      end
    end
    repeat (3) @(posedge HCLK);
    $display("Summary: %0d passed, %0d failed, %0d timed out",
             pass_count, fail_count, timeouts);
    if (fail_count == 0 && timeouts == 0 && pass_count == n_ops + 1) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/dbg_ahb_checker.sv ====
////////////////////////////////////////////////////////////
// Result checker, watches both debug ports and compares each
// completed request against the expectation set by the bench
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dbg_ahb_checker
  import dbg_ahb_pkg::*;
(
  input  logic                       HCLK,
  input  logic                       ahb_rstn,
  // Observed port outputs, index is the port number
  input  logic [1:0]                 rdy,
  input  logic [1:0]                 err,
  input  logic [1:0][data_width-1:0] rdata,
  // Expectation of the request in flight on each port
  input  logic [1:0][data_width-1:0] exp_rdata,
  input  logic [1:0]                 exp_err,
  input  logic [1:0]                 exp_chk,
  input  logic [1:0][7:0]            test_no,
  output int                         pass_count,
  output int                         fail_count
);

  logic [1:0] rdy_q;
  bit         reset_seen;

  // Idle state right after reset release
  task automatic check_reset_state();
    if (rdy === 2'b11 && err === 2'b00) begin
      pass_count++;
      $display("test 0 reset state ok, rdy %b err %b", rdy, err);
    end else begin
      fail_count++;
      $display("FAILED t=%0t test 0: after reset rdy %b err %b, expected 11 and 00",
               $time, rdy, err);
    end
  endtask

  // Read data only matters for reads that complete without error
  task automatic check_result(input int p);
    logic data_bad;
    logic err_bad;
    data_bad = exp_chk[p] && (rdata[p] !== exp_rdata[p]);
    err_bad  = (err[p] !== exp_err[p]);
    if (data_bad || err_bad) begin
      fail_count++;
      $display("FAILED t=%0t test %0d port %0d: rdata %08h (exp %08h) err %b (exp %b)",
               $time, test_no[p], p, rdata[p], exp_rdata[p], err[p], exp_err[p]);
    end else begin
      pass_count++;
      $display("test %0d port %0d ok, rdata %08h err %b",
               test_no[p], p, rdata[p], err[p]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Completion detect
  ////////////////////////////////////////////////////////////

  // Sampled on the edge, so values are those settled before it
  always @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rdy_q      = 2'b11;
      reset_seen = 1'b0;
    end else begin
      if (!reset_seen) begin
        check_reset_state();
        reset_seen = 1'b1;
      end
      // Rising rdy marks a finished request
      for (int p = 0; p < 2; p++) begin
        if (rdy[p] && !rdy_q[p]) begin
          check_result(p);
        end
      end
      rdy_q = rdy;
    end
  end

endmodule

`default_nettype wire

// ==== design/dbg_ahb_top.sv ====
////////////////////////////////////////////////////////////
// Two-port debug bus hub, two interface units share one
// AHB-Lite bus through the arbiter to the SRAM slave
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dbg_ahb_top
  import dbg_ahb_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  // Debug port 0
  input  logic                  dbg_strb_0,
  input  logic                  dbg_rw_0,
  input  logic [addr_width-1:0] dbg_addr_0,
  input  logic [data_width-1:0] dbg_wdata_0,
  input  logic [3:0]            dbg_word_size_0,
  output logic [data_width-1:0] dbg_rdata_0,
  output logic                  dbg_rdy_0,
  output logic                  dbg_err_0,
  // Debug port 1
  input  logic                  dbg_strb_1,
  input  logic                  dbg_rw_1,
  input  logic [addr_width-1:0] dbg_addr_1,
  input  logic [data_width-1:0] dbg_wdata_1,
  input  logic [3:0]            dbg_word_size_1,
  output logic [data_width-1:0] dbg_rdata_1,
  output logic                  dbg_rdy_1,
  output logic                  dbg_err_1
);

  // Master side nets
  logic                  m0_bus_req, m1_bus_req;
  logic [addr_width-1:0] m0_haddr, m1_haddr;
  logic                  m0_hwrite, m1_hwrite;
  logic [2:0]            m0_hsize, m1_hsize;
  logic [1:0]            m0_htrans, m1_htrans;
  logic [data_width-1:0] m0_hwdata, m1_hwdata;
  logic                  m0_bus_gnt, m1_bus_gnt;
  logic                  m0_hready, m1_hready;
  logic [data_width-1:0] m0_hrdata, m1_hrdata;
  logic                  m0_hresp, m1_hresp;

  // Shared slave bus
  logic [addr_width-1:0] haddr;
  logic                  hwrite;
  logic [2:0]            hsize;
  logic [1:0]            htrans;
  logic [data_width-1:0] hwdata;
  logic                  hreadyout;
  logic [data_width-1:0] hrdata;
  logic                  hresp;

  dbg_biu_ahb u_biu0 (
    .HCLK          (HCLK),
    .ahb_rstn      (ahb_rstn),
    .dbg_strb      (dbg_strb_0),
    .dbg_rw        (dbg_rw_0),
    .dbg_addr      (dbg_addr_0),
    .dbg_wdata     (dbg_wdata_0),
    .dbg_word_size (dbg_word_size_0),
    .dbg_rdata     (dbg_rdata_0),
    .dbg_rdy       (dbg_rdy_0),
    .dbg_err       (dbg_err_0),
    .bus_req       (m0_bus_req),
    .haddr         (m0_haddr),
    .hwrite        (m0_hwrite),
    .hsize         (m0_hsize),
    .htrans        (m0_htrans),
    .hwdata        (m0_hwdata),
    .bus_gnt       (m0_bus_gnt),
    .hready        (m0_hready),
    .hrdata        (m0_hrdata),
    .hresp         (m0_hresp)
  );

  dbg_biu_ahb u_biu1 (
    .HCLK          (HCLK),
    .ahb_rstn      (ahb_rstn),
    .dbg_strb      (dbg_strb_1),
    .dbg_rw        (dbg_rw_1),
    .dbg_addr      (dbg_addr_1),
    .dbg_wdata     (dbg_wdata_1),
    .dbg_word_size (dbg_word_size_1),
    .dbg_rdata     (dbg_rdata_1),
    .dbg_rdy       (dbg_rdy_1),
    .dbg_err       (dbg_err_1),
    .bus_req       (m1_bus_req),
    .haddr         (m1_haddr),
    .hwrite        (m1_hwrite),
    .hsize         (m1_hsize),
    .htrans        (m1_htrans),
    .hwdata        (m1_hwdata),
    .bus_gnt       (m1_bus_gnt),
    .hready        (m1_hready),
    .hrdata        (m1_hrdata),
    .hresp         (m1_hresp)
  );

  ahb_master_arbiter u_arb (
    .HCLK       (HCLK),
    .ahb_rstn   (ahb_rstn),
    .m0_bus_req (m0_bus_req),
    .m0_haddr   (m0_haddr),
    .m0_hwrite  (m0_hwrite),
    .m0_hsize   (m0_hsize),
    .m0_htrans  (m0_htrans),
    .m0_hwdata  (m0_hwdata),
    .m0_bus_gnt (m0_bus_gnt),
    .m0_hready  (m0_hready),
    .m0_hrdata  (m0_hrdata),
    .m0_hresp   (m0_hresp),
    .m1_bus_req (m1_bus_req),
    .m1_haddr   (m1_haddr),
    .m1_hwrite  (m1_hwrite),
    .m1_hsize   (m1_hsize),
    .m1_htrans  (m1_htrans),
    .m1_hwdata  (m1_hwdata),
    .m1_bus_gnt (m1_bus_gnt),
    .m1_hready  (m1_hready),
    .m1_hrdata  (m1_hrdata),
    .m1_hresp   (m1_hresp),
    .haddr      (haddr),
    .hwrite     (hwrite),
    .hsize      (hsize),
    .htrans     (htrans),
    .hwdata     (hwdata),
    .hreadyout  (hreadyout),
    .hrdata     (hrdata),
    .hresp      (hresp)
  );

  // hready is the slave's own hreadyout fed back
  ahb_sram_slave u_sram (
    .HCLK      (HCLK),
    .ahb_rstn  (ahb_rstn),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .htrans    (htrans),
    .hwdata    (hwdata),
    .hready    (hreadyout),
    .hreadyout (hreadyout),
    .hrdata    (hrdata),
    .hresp     (hresp)
  );

endmodule

`default_nettype wire

// ==== design/ahb_sram_slave.sv ====
////////////////////////////////////////////////////////////
// AHB-Lite SRAM slave, one wait state per transfer, byte-lane
// writes and a two-cycle ERROR above the memory range
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ahb_sram_slave
  import dbg_ahb_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  input  logic [addr_width-1:0] haddr,
  input  logic                  hwrite,
  input  logic [2:0]            hsize,
  input  logic [1:0]            htrans,
  input  logic [data_width-1:0] hwdata,
  input  logic                  hready,
  output logic                  hreadyout,
  output logic [data_width-1:0] hrdata,
  output logic                  hresp
);

  logic [data_width-1:0]    mem [mem_words];
  logic [mem_idx_width+1:0] addr_q;
  logic                     write_q;
  logic [2:0]               size_q;
  logic                     wait_q;
  logic                     start;
  logic                     out_range;
  logic                     wr_en;
  logic [mem_idx_width-1:0] idx;
  ahb_word_u                old_w;
  ahb_word_u                new_w;
  ahb_word_u                merged;

  ////////////////////////////////////////////////////////////
  // Address phase and response
  ////////////////////////////////////////////////////////////

  // Address phase sampled only when the bus is ready
  assign start     = hready & (htrans == htrans_nonseq);
  assign out_range = (haddr >= mem_bytes);

  always_ff @(posedge HCLK) begin
    if (start) begin
      addr_q  <= haddr[mem_idx_width+1:0];
      write_q <= hwrite;
      size_q  <= hsize;
    end
  end

  // First data cycle is the wait state, second completes
  // ERROR keeps hresp high across both cycles
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      wait_q    <= 1'b0;
      hreadyout <= 1'b1;
      hresp     <= 1'b0;
    end else if (start) begin
      wait_q    <= 1'b1;
      hreadyout <= 1'b0;
      hresp     <= out_range;
    end else if (wait_q) begin
      wait_q    <= 1'b0;
      hreadyout <= 1'b1;
    end else begin
      hresp <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Word array
  ////////////////////////////////////////////////////////////

  assign idx = addr_q[mem_idx_width+1:2];

  // Write at the end of the wait state, never on an error
  assign wr_en = wait_q & write_q & ~hresp;

  // Only the lanes picked by size and low address bits change
  always_comb begin
    old_w.w = mem[idx];
    new_w.w = hwdata;
    merged  = old_w;
    case (size_q)
      hsize_byte: merged.b[addr_q[1:0]] = new_w.b[addr_q[1:0]];
      hsize_half: merged.h[addr_q[1]] = new_w.h[addr_q[1]];
      default:    merged = new_w;
    endcase
  end

  // Array cleared to zero by reset
  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[idx] <= merged.w;
    end
  end

  // Read word presented with hreadyout high
  always_ff @(posedge HCLK) begin
    if (wait_q) begin
      hrdata <= hresp ? '0 : mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== design/ahb_master_arbiter.sv ====
////////////////////////////////////////////////////////////
// Round-robin arbiter for two AHB-Lite masters, muxes the
// address and data phases onto a single slave bus
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ahb_master_arbiter
  import dbg_ahb_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  // Master 0
  input  logic                  m0_bus_req,
  input  logic [addr_width-1:0] m0_haddr,
  input  logic                  m0_hwrite,
  input  logic [2:0]            m0_hsize,
  input  logic [1:0]            m0_htrans,
  input  logic [data_width-1:0] m0_hwdata,
  output logic                  m0_bus_gnt,
  output logic                  m0_hready,
  output logic [data_width-1:0] m0_hrdata,
  output logic                  m0_hresp,
  // Master 1
  input  logic                  m1_bus_req,
  input  logic [addr_width-1:0] m1_haddr,
  input  logic                  m1_hwrite,
  input  logic [2:0]            m1_hsize,
  input  logic [1:0]            m1_htrans,
  input  logic [data_width-1:0] m1_hwdata,
  output logic                  m1_bus_gnt,
  output logic                  m1_hready,
  output logic [data_width-1:0] m1_hrdata,
  output logic                  m1_hresp,
  // Slave bus
  output logic [addr_width-1:0] haddr,
  output logic                  hwrite,
  output logic [2:0]            hsize,
  output logic [1:0]            htrans,
  output logic [data_width-1:0] hwdata,
  input  logic                  hreadyout,
  input  logic [data_width-1:0] hrdata,
  input  logic                  hresp
);

  logic gnt_vld;
  logic gnt_sel;
  logic last_sel;
  logic dp_vld;
  logic dp_sel;
  logic busy;
  logic own_sel;

  ////////////////////////////////////////////////////////////
  // Grant and data phase ownership
  ////////////////////////////////////////////////////////////

  // Grant frozen while an address or data phase is in flight
  assign busy = dp_vld | (htrans == htrans_nonseq);

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      gnt_vld  <= 1'b0;
      gnt_sel  <= 1'b0;
      last_sel <= 1'b1;
      dp_vld   <= 1'b0;
      dp_sel   <= 1'b0;
    end else begin
      if (!busy) begin
        gnt_vld <= m0_bus_req | m1_bus_req;
        // Contention goes to the master not served last
        if (m0_bus_req && m1_bus_req) begin
          gnt_sel <= ~last_sel;
        end else if (m0_bus_req || m1_bus_req) begin
          gnt_sel <= m1_bus_req;
        end
      end
      // Accepted NONSEQ opens a data phase for the granted master
      if (htrans == htrans_nonseq && hreadyout) begin
        dp_vld   <= 1'b1;
        dp_sel   <= gnt_sel;
        last_sel <= gnt_sel;
      end else if (dp_vld && hreadyout) begin
        dp_vld <= 1'b0;
      end
    end
  end

  assign m0_bus_gnt = gnt_vld & ~gnt_sel;
  assign m1_bus_gnt = gnt_vld & gnt_sel;

  ////////////////////////////////////////////////////////////
  // Bus muxing
  ////////////////////////////////////////////////////////////

  // Address phase from the granted master
  assign haddr  = gnt_sel ? m1_haddr : m0_haddr;
  assign hwrite = gnt_sel ? m1_hwrite : m0_hwrite;
  assign hsize  = gnt_sel ? m1_hsize : m0_hsize;
  assign htrans = !gnt_vld ? htrans_idle : (gnt_sel ? m1_htrans : m0_htrans);

  // Write data from the data phase owner
  assign hwdata = dp_sel ? m1_hwdata : m0_hwdata;

  // Responses go to the owner, or the granted master between transfers
  assign own_sel = dp_vld ? dp_sel : gnt_sel;

  assign m0_hready = hreadyout & ~own_sel;
  assign m1_hready = hreadyout & own_sel;
  assign m0_hrdata = own_sel ? '0 : hrdata;
  assign m1_hrdata = own_sel ? hrdata : '0;
  assign m0_hresp  = hresp & ~own_sel;
  assign m1_hresp  = hresp & own_sel;

endmodule

`default_nettype wire

// ==== design/dbg_biu_ahb.sv ====
////////////////////////////////////////////////////////////
// Debug bus interface unit, turns one debug strobe into one
// single AHB-Lite transfer and returns the lane-aligned result
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dbg_biu_ahb
  import dbg_ahb_pkg::*;
(
  input  logic                  HCLK,
  input  logic                  ahb_rstn,
  // Debug strobe side
  input  logic                  dbg_strb,
  input  logic                  dbg_rw,
  input  logic [addr_width-1:0] dbg_addr,
  input  logic [data_width-1:0] dbg_wdata,
  input  logic [3:0]            dbg_word_size,
  output logic [data_width-1:0] dbg_rdata,
  output logic                  dbg_rdy,
  output logic                  dbg_err,
  // Master side toward the arbiter
  output logic                  bus_req,
  output logic [addr_width-1:0] haddr,
  output logic                  hwrite,
  output logic [2:0]            hsize,
  output logic [1:0]            htrans,
  output logic [data_width-1:0] hwdata,
  input  logic                  bus_gnt,
  input  logic                  hready,
  input  logic [data_width-1:0] hrdata,
  input  logic                  hresp
);

  // Burst, protection and lock are fixed by the package
  // (single, hprot_dbg, unlocked) and never leave this unit

  logic [1:0] state;
  logic       take;
  logic       done;
  logic [2:0] size_dec;
  ahb_word_u  wr_rep;
  ahb_word_u  rd_lane;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Request accepted only while ready
  assign take = dbg_strb & dbg_rdy;

  // Word size in bytes to AHB size code
  always_comb begin
    case (dbg_word_size)
      4'd1:    size_dec = hsize_byte;
      4'd2:    size_dec = hsize_half;
      default: size_dec = hsize_word;
    endcase
  end

  // Low bytes of write data copied onto every lane
  always_comb begin
    case (dbg_word_size)
      4'd1:    wr_rep.b = {4{dbg_wdata[7:0]}};
      4'd2:    wr_rep.h = {2{dbg_wdata[15:0]}};
      default: wr_rep.w = dbg_wdata;
    endcase
  end

  // Address phase payload, held for the whole transfer
  always_ff @(posedge HCLK) begin
    if (take) begin
      haddr  <= dbg_addr;
      hwrite <= ~dbg_rw;
      hsize  <= size_dec;
      hwdata <= wr_rep.w;
    end
  end

  ////////////////////////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////////////////////////

  // Request held from the cycle after take until data phase ends
  assign bus_req = (state != biu_idle);

  // NONSEQ only while granted in the address state
  assign htrans = (state == biu_addr && bus_gnt) ? htrans_nonseq : htrans_idle;

  // Data phase finishes on hready
  assign done = (state == biu_data) & hready;

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      state   <= biu_idle;
      dbg_rdy <= 1'b1;
      dbg_err <= 1'b0;
    end else begin
      case (state)
        biu_idle: begin
          if (take) begin
            state   <= biu_addr;
            dbg_rdy <= 1'b0;
          end
        end
        // Address phase taken when granted and the bus is ready
        biu_addr: begin
          if (bus_gnt && hready) begin
            state <= biu_data;
          end
        end
        // Result and error status latched together with rdy
        biu_data: begin
          if (hready) begin
            state   <= biu_idle;
            dbg_rdy <= 1'b1;
            dbg_err <= hresp;
          end
        end
        default: state <= biu_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Read return
  ////////////////////////////////////////////////////////////

  assign rd_lane.w = hrdata;

  // Addressed lane shifted down and zero-extended
  always_ff @(posedge HCLK) begin
    if (done) begin
      case (hsize)
        hsize_byte: dbg_rdata <= {24'b0, rd_lane.b[haddr[1:0]]};
        hsize_half: dbg_rdata <= {16'b0, rd_lane.h[haddr[1]]};
        default:    dbg_rdata <= rd_lane.w;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/dbg_ahb_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared AHB-Lite codes, memory sizing and lane view for the
// debug bus hub, taken by wildcard import in each module
////////////////////////////////////////////////////////////

`default_nettype none

package dbg_ahb_pkg;

  // Bus widths
  localparam int data_width = 32;
  localparam int addr_width = 32;

  // SRAM sizing, legal bytes are 0 .. mem_bytes-1
  localparam int mem_words = 256;
  localparam int mem_idx_width = $clog2(mem_words);
  localparam logic [addr_width-1:0] mem_bytes = mem_words * 4;

  // Transfer type
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  // Transfer size
  localparam logic [2:0] hsize_byte = 3'b000;
  localparam logic [2:0] hsize_half = 3'b001;
  localparam logic [2:0] hsize_word = 3'b010;

  // Fixed attributes of every debug access
  // Single transfer only
  localparam logic [2:0] hburst_single = 3'b000;
  // Data, privileged, non-bufferable, non-cacheable
  localparam logic [3:0] hprot_dbg = 4'b0011;

  // Interface unit FSM
  localparam logic [1:0] biu_idle = 2'd0;
  localparam logic [1:0] biu_addr = 2'd1;
  localparam logic [1:0] biu_data = 2'd2;

  // One bus word seen as word, halfword lanes or byte lanes
  // Lane 0 is the least significant, little-endian order
  typedef union packed {
    logic [data_width-1:0] w;
    logic [1:0][15:0]      h;
    logic [3:0][7:0]       b;
  } ahb_word_u;

endpackage

`default_nettype wire
